//--- dv/l3SubsystemTb.sv
`timescale 1ns/1ns

module l3SubsystemTb;

    localparam int MEM_LINES = 1024;
    localparam int TIMEOUT = 1000; // cycles allowed per wait.
    localparam int RSP_DELAY = 3;

    logic clk;
    logic reset;
    logic reqValid;
    logic reqWrite;
    cachePkg::addrT reqAddr;
    cachePkg::wordT reqWriteData;
    logic reqReady;
    logic rspValid;
    cachePkg::wordT rspData;
    logic rspHit;
    logic memReqValid;
    logic memReqWrite;
    cachePkg::lineAddrT memReqLineAddr;
    cachePkg::lineT memReqData;
    logic memCredit;
    logic memRspValid;
    cachePkg::lineT memRspData;
    logic csrWrite;
    cachePkg::csrAddrT csrAddr;
    cachePkg::wordT csrWriteData;
    cachePkg::cntT csrReadData;

    tbClock clock_i (.clk(clk), .reset(reset));

    l3Subsystem dut_i (.*);

    // memory model.
    cachePkg::lineT memArr [MEM_LINES];
    int cycle;
    int creditDelay;
    int creditDue [$];
    int rspDue [$];
    cachePkg::lineT rspLine [$];
    logic reqKindLog [$];              // 1 for a write.
    cachePkg::lineAddrT reqAddrLog [$];
    cachePkg::lineT reqDataLog [$];

    // reference model.
    cachePkg::tagT refTag [cachePkg::NUM_LINES];
    logic refValid [cachePkg::NUM_LINES];
    logic refDirty [cachePkg::NUM_LINES];
    cachePkg::lineT refData [cachePkg::NUM_LINES];
    cachePkg::lineT refMem [MEM_LINES];
    cachePkg::cntT expHits;
    cachePkg::cntT expMisses;
    cachePkg::cntT expWriteBacks;

    logic [31:0] lcgState;

    function automatic cachePkg::wordT nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [9:0] memSlot(input cachePkg::lineAddrT lineAddr);
        return lineAddr[9:0];
    endfunction

    function automatic cachePkg::addrT makeAddr(input int lineNum, input int word);
        return (cachePkg::addrT'(lineNum) << cachePkg::OFFSET_BITS) | cachePkg::addrT'(word);
    endfunction

    // ****************************************
    // memory with credit return.
    // ****************************************
    always @(posedge clk) begin
        if (reset) begin
            memCredit <= 1'b0;
            memRspValid <= 1'b0;
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            if (memReqValid) begin
                reqKindLog.push_back(memReqWrite);
                reqAddrLog.push_back(memReqLineAddr);
                reqDataLog.push_back(memReqData);
                creditDue.push_back(cycle + creditDelay);
                if (memReqWrite) begin
                    memArr[memSlot(memReqLineAddr)] = memReqData;
                end else begin
                    rspDue.push_back(cycle + RSP_DELAY);
                    rspLine.push_back(memArr[memSlot(memReqLineAddr)]);
                end
            end
            memCredit <= 1'b0;
            if (creditDue.size() > 0 && creditDue[0] <= cycle) begin
                memCredit <= 1'b1; // one credit per cycle at most.
                void'(creditDue.pop_front());
            end
            memRspValid <= 1'b0;
            if (rspDue.size() > 0 && rspDue[0] <= cycle) begin
                memRspValid <= 1'b1;
                memRspData <= rspLine.pop_front();
                void'(rspDue.pop_front());
            end
        end
    end

    // ****************************************
    // compare tasks.
    // ****************************************
    task automatic abortRun(input string reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkWord(input string name, input cachePkg::wordT got,
                             input cachePkg::wordT exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            abortRun("data mismatch");
        end
    endtask

    task automatic checkHit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            abortRun("flag mismatch");
        end
    endtask

    task automatic checkCount(input string name, input cachePkg::cntT got,
                              input cachePkg::cntT exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            abortRun("count mismatch");
        end
    endtask

    task automatic checkLineAddr(input string name, input cachePkg::lineAddrT got,
                                 input cachePkg::lineAddrT exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            abortRun("line address mismatch");
        end
    endtask

    task automatic checkLine(input string name, input cachePkg::lineT got,
                             input cachePkg::lineT exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            abortRun("line mismatch");
        end
    endtask

    // ****************************************
    // reference model and drivers.
    // ****************************************
    function automatic void predict(input cachePkg::addrT addr, input logic write,
                                    input cachePkg::wordT wdata, output logic hit,
                                    output cachePkg::wordT data, output logic wb,
                                    output cachePkg::lineAddrT wbAddr,
                                    output cachePkg::lineT wbLine);
        cachePkg::tagT tag;
        cachePkg::indexT idx;
        cachePkg::offsetT off;

        {tag, idx, off} = addr;
        hit = refValid[idx] && (refTag[idx] == tag);
        wb = !hit && refValid[idx] && refDirty[idx];
        wbAddr = {refTag[idx], idx};
        wbLine = refData[idx];
        if (hit) begin
            expHits = expHits + 1;
        end else begin
            expMisses = expMisses + 1;
        end
        if (wb) begin
            refMem[memSlot(wbAddr)] = wbLine;
            expWriteBacks = expWriteBacks + 1;
        end
        if (!hit) begin
            refData[idx] = refMem[memSlot({tag, idx})];
            refTag[idx] = tag;
            refValid[idx] = 1'b1;
            refDirty[idx] = 1'b0;
        end
        if (write) begin
            refData[idx][off*cachePkg::WORD_BITS +: cachePkg::WORD_BITS] = wdata;
            refDirty[idx] = 1'b1;
        end
        data = refData[idx][off*cachePkg::WORD_BITS +: cachePkg::WORD_BITS];
    endfunction

    task automatic waitForReset();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) abortRun("reset was never released");
        end while (reset);
    endtask

    // one request, its response and the memory traffic it caused.
    task automatic access(input cachePkg::addrT addr, input logic write,
                          input cachePkg::wordT wdata, output logic hitSeen);
        logic expHit;
        cachePkg::wordT expData;
        logic expWb;
        cachePkg::lineAddrT wbAddr;
        cachePkg::lineT wbLine;
        int waited;
        int expReqs;

        predict(addr, write, wdata, expHit, expData, expWb, wbAddr, wbLine);
        reqKindLog.delete();
        reqAddrLog.delete();
        reqDataLog.delete();
        reqValid <= 1'b1;
        reqWrite <= write;
        reqAddr <= addr;
        reqWriteData <= wdata;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) abortRun("request was never accepted");
        end while (!reqReady);
        reqValid <= 1'b0;

        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) abortRun("no response to an accepted request");
        end while (!rspValid);
        hitSeen = rspHit;
        checkHit("rspHit", rspHit, expHit);
        checkWord("rspData", rspData, expData);
        if (expHit) checkCount("hitLatency", cachePkg::cntT'(waited), 1);

        expReqs = expHit ? 0 : (expWb ? 2 : 1);
        checkCount("memRequests", cachePkg::cntT'(reqKindLog.size()), cachePkg::cntT'(expReqs));
        if (expWb) begin
            checkHit("memReqWrite", reqKindLog[0], 1'b1); // victim goes out first.
            checkLineAddr("memReqLineAddr", reqAddrLog[0], wbAddr);
            checkLine("memReqData", reqDataLog[0], wbLine);
            checkLine("memWrittenBack", memArr[memSlot(wbAddr)], wbLine);
        end
        if (!expHit) begin
            checkHit("memReqWrite", reqKindLog[expReqs-1], 1'b0);
            checkLineAddr("memReqLineAddr", reqAddrLog[expReqs-1],
                          addr[cachePkg::WORD_BITS-1:cachePkg::OFFSET_BITS]);
        end
    endtask

    task automatic writeCsr(input cachePkg::csrAddrT addr, input cachePkg::wordT data);
        csrWrite <= 1'b1;
        csrAddr <= addr;
        csrWriteData <= data;
        @(posedge clk);
        csrWrite <= 1'b0;
    endtask

    task automatic checkCsr(input string name, input cachePkg::csrAddrT addr,
                            input cachePkg::cntT exp);
        csrAddr <= addr;
        @(posedge clk);
        checkCount(name, csrReadData, exp);
    endtask

    task automatic clearCounters();
        writeCsr(cachePkg::CSR_CMD, cachePkg::wordT'(1 << cachePkg::CMD_CLEAR_BIT));
        expHits = '0;
        expMisses = '0;
        expWriteBacks = '0;
    endtask

    task automatic invalidateCache();
        writeCsr(cachePkg::CSR_CMD, cachePkg::wordT'(1 << cachePkg::CMD_INVAL_BIT));
        for (int i = 0; i < cachePkg::NUM_LINES; i++) begin
            refValid[i] = 1'b0; // dirty data is dropped, not written.
            refDirty[i] = 1'b0;
        end
    endtask

    // ****************************************
    // directed tests.
    // ****************************************
    task automatic readMissThenHit();
        logic hitSeen;
        access(makeAddr(5, 0), 1'b0, '0, hitSeen);
        checkHit("firstReadHit", hitSeen, 1'b0);
        access(makeAddr(5, 2), 1'b0, '0, hitSeen);
        checkHit("secondReadHit", hitSeen, 1'b1);
    endtask

    task automatic writeHitThenRead();
        logic hitSeen;
        access(makeAddr(5, 1), 1'b1, 32'ha5a5_0001, hitSeen);
        checkHit("writeHit", hitSeen, 1'b1);
        access(makeAddr(5, 1), 1'b0, '0, hitSeen);
    endtask

    task automatic dirtyEviction();
        logic hitSeen;
        access(makeAddr(6, 3), 1'b1, 32'hdead_0006, hitSeen); // allocates and dirties line 6.
        access(makeAddr(6 + cachePkg::NUM_LINES, 1), 1'b0, '0, hitSeen);
        checkCount("writeBackRequests", cachePkg::cntT'(reqKindLog.size()), 2);
    endtask

    task automatic statistics();
        logic hitSeen;
        clearCounters();
        access(makeAddr(7, 0), 1'b0, '0, hitSeen);
        access(makeAddr(7, 1), 1'b1, 32'h0000_7777, hitSeen);
        access(makeAddr(7 + cachePkg::NUM_LINES, 2), 1'b0, '0, hitSeen);
        access(makeAddr(7 + cachePkg::NUM_LINES, 3), 1'b0, '0, hitSeen);
        checkCsr("hitCount", cachePkg::CSR_HITS, expHits);
        checkCsr("missCount", cachePkg::CSR_MISSES, expMisses);
        checkCsr("writeBackCount", cachePkg::CSR_WRITE_BACKS, expWriteBacks);
        clearCounters();
        checkCsr("hitCount", cachePkg::CSR_HITS, '0);
        checkCsr("missCount", cachePkg::CSR_MISSES, '0);
        checkCsr("writeBackCount", cachePkg::CSR_WRITE_BACKS, '0);
    endtask

    task automatic invalidateLines();
        logic hitSeen;
        access(makeAddr(8, 0), 1'b1, 32'h1111_0008, hitSeen);
        access(makeAddr(9, 1), 1'b1, 32'h2222_0009, hitSeen);
        invalidateCache();
        access(makeAddr(8, 0), 1'b0, '0, hitSeen);
        checkHit("readAfterInvalidateHit", hitSeen, 1'b0);
        access(makeAddr(9, 1), 1'b0, '0, hitSeen);
        checkHit("readAfterInvalidateHit", hitSeen, 1'b0);
        checkLine("memArr[8]", memArr[8], refMem[8]);
    endtask

    task automatic randomTraffic();
        logic hitSeen;
        cachePkg::wordT r;
        creditDelay = 40; // slow enough to run out of credits.
        for (int n = 0; n < 200; n++) begin
            r = nextRandom();
            access(makeAddr(int'(r[29:24]), int'(r[21:20])), r[31], nextRandom(), hitSeen);
        end
        for (int i = 0; i < MEM_LINES; i++) begin
            checkLine($sformatf("memArr[%0d]", i), memArr[i], refMem[i]);
        end
    endtask

    initial begin
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqAddr = '0;
        reqWriteData = '0;
        csrWrite = 1'b0;
        csrAddr = '0;
        csrWriteData = '0;
        memCredit = 1'b0;
        memRspValid = 1'b0;
        memRspData = '0;
        creditDelay = 4;
        expHits = '0;
        expMisses = '0;
        expWriteBacks = '0;
        lcgState = 32'h0c1c_0b01;
        for (int i = 0; i < MEM_LINES; i++) begin
            for (int w = 0; w < cachePkg::LINE_WORDS; w++) begin
                memArr[i][w*cachePkg::WORD_BITS +: cachePkg::WORD_BITS] = nextRandom();
            end
            refMem[i] = memArr[i];
        end
        for (int i = 0; i < cachePkg::NUM_LINES; i++) begin
            refValid[i] = 1'b0;
            refDirty[i] = 1'b0;
            refTag[i] = '0;
            refData[i] = '0;
        end

        waitForReset();
        readMissThenHit();
        writeHitThenRead();
        dirtyEviction();
        statistics();
        invalidateLines();
        randomTraffic();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- dv/l3Subsystem_props.sv
`timescale 1ns/1ns

module l3SubsystemProps (
    input logic clk,
    input logic reset,
    input logic reqValid,
    input logic reqReady,
    input logic rspValid,
    input logic memReqValid,
    input logic memCredit
);

    int inFlight;  // requests the memory has seen and not yet paid back.
    logic pending; // accepted request still waiting for its response.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            inFlight <= 0;
        end else begin
            case ({memReqValid, memCredit})
                2'b10: inFlight <= inFlight + 1;
                2'b01: inFlight <= inFlight - 1;
                default: inFlight <= inFlight;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (reqValid && reqReady) begin
            pending <= 1'b1;
        end else if (rspValid) begin
            pending <= 1'b0;
        end
    end

    // memory never sees more requests than the credits it granted.
    sendWithinCredits: assert property (
        @(posedge clk) disable iff (reset) memReqValid |-> (inFlight < cachePkg::MEM_CREDITS)
    ) else $error("memory request sent without a credit");

    // one single-cycle response for each accepted request.
    rspPerRequest: assert property (
        @(posedge clk) disable iff (reset) rspValid |-> pending
    ) else $error("response without an accepted request");

    busyDuringMiss: assert property (
        @(posedge clk) disable iff (reset) (pending && !rspValid) |-> !reqReady
    ) else $error("request ready while a miss is pending");

endmodule

bind l3Subsystem l3SubsystemProps props_i (
    .clk(clk),
    .reset(reset),
    .reqValid(reqValid),
    .reqReady(reqReady),
    .rspValid(rspValid),
    .memReqValid(memReqValid),
    .memCredit(memCredit)
);

//--- dv/tbClock.sv
`timescale 1ns/1ns

module tbClock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period.
    end

    // reset held over the first three rising edges.
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- hw/cacheCsr.sv
`timescale 1ns/1ns

module cacheCsr (
    input logic clk,
    input logic reset,
    input logic csrWrite,
    input cachePkg::csrAddrT csrAddr,
    input cachePkg::wordT csrWriteData,
    output cachePkg::cntT csrReadData,
    cacheEventIf.csr ev
);

    cachePkg::cntT hitCnt;
    cachePkg::cntT missCnt;
    cachePkg::cntT writeBackCnt;
    logic cmdWrite;
    logic clearCnt;

    assign cmdWrite = csrWrite && (csrAddr == cachePkg::CSR_CMD);
    assign clearCnt = cmdWrite && csrWriteData[cachePkg::CMD_CLEAR_BIT];

    // ****************************************
    // statistics counters.
    // ****************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hitCnt <= '0;
            missCnt <= '0;
            writeBackCnt <= '0;
        end else if (clearCnt) begin
            hitCnt <= '0; // clear wins over a same-cycle event.
            missCnt <= '0;
            writeBackCnt <= '0;
        end else begin
            if (ev.hitEv) hitCnt <= hitCnt + 1'b1;
            if (ev.missEv) missCnt <= missCnt + 1'b1;
            if (ev.writeBackEv) writeBackCnt <= writeBackCnt + 1'b1;
        end
    end

    // invalidate pulse, one cycle after the command write.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ev.invalidate <= 1'b0;
        end else begin
            ev.invalidate <= cmdWrite && csrWriteData[cachePkg::CMD_INVAL_BIT];
        end
    end

    always_comb begin
        case (csrAddr)
            cachePkg::CSR_HITS: csrReadData = hitCnt;
            cachePkg::CSR_MISSES: csrReadData = missCnt;
            cachePkg::CSR_WRITE_BACKS: csrReadData = writeBackCnt;
            default: csrReadData = '0; // command register reads as zero.
        endcase
    end

endmodule

//--- hw/cacheEventIf.sv
`timescale 1ns/1ns

interface cacheEventIf;
    // single-cycle pulses from the controller.
    logic hitEv;
    logic missEv;
    logic writeBackEv;
    logic invalidate; // drops every line, dirty or not.

    modport ctrl (
        output hitEv, missEv, writeBackEv,
        input invalidate
    );

    modport csr (
        input hitEv, missEv, writeBackEv,
        output invalidate
    );
endinterface

//--- hw/cachePkg.sv
package cachePkg;

    // ****************************************
    // cache geometry.
    // ****************************************
    localparam int WORD_BITS = 32;
    localparam int LINE_WORDS = 4;
    localparam int NUM_LINES = 16;
    localparam int OFFSET_BITS = $clog2(LINE_WORDS);
    localparam int INDEX_BITS = $clog2(NUM_LINES);
    localparam int TAG_BITS = WORD_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int LINE_ADDR_BITS = TAG_BITS + INDEX_BITS;
    localparam int LINE_BITS = WORD_BITS * LINE_WORDS;

    localparam int MEM_CREDITS = 2; // granted by memory after reset.
    localparam int CREDIT_BITS = $clog2(MEM_CREDITS + 1);

    typedef logic [WORD_BITS-1:0] wordT;
    typedef logic [WORD_BITS-1:0] addrT;
    typedef logic [OFFSET_BITS-1:0] offsetT;
    typedef logic [INDEX_BITS-1:0] indexT;
    typedef logic [TAG_BITS-1:0] tagT;
    typedef logic [LINE_ADDR_BITS-1:0] lineAddrT; // {tag, index}.
    typedef logic [LINE_BITS-1:0] lineT;          // word 0 in the low bits.
    typedef logic [CREDIT_BITS-1:0] creditT;
    typedef logic [31:0] cntT;
    typedef logic [1:0] csrAddrT;

    // register map and command bits.
    localparam csrAddrT CSR_HITS = 2'd0;
    localparam csrAddrT CSR_MISSES = 2'd1;
    localparam csrAddrT CSR_WRITE_BACKS = 2'd2;
    localparam csrAddrT CSR_CMD = 2'd3;
    localparam int CMD_CLEAR_BIT = 0;
    localparam int CMD_INVAL_BIT = 1;

    typedef enum logic [2:0] {
        idle,
        writeBack,
        fillReq,
        fillWait,
        respond
    } ctrlStateT;

endpackage

//--- hw/l3Cache.sv
`timescale 1ns/1ns

module l3Cache (
    input logic clk,
    input logic reset,
    input logic reqValid,
    input logic reqWrite,
    input cachePkg::addrT reqAddr,
    input cachePkg::wordT reqWriteData,
    output logic reqReady,
    output logic rspValid,
    output cachePkg::wordT rspData,
    output logic rspHit,
    memReqIf.cache mem,
    cacheEventIf.ctrl ev
);

    cachePkg::ctrlStateT state;
    logic initDone;

    cachePkg::tagT tagArr [cachePkg::NUM_LINES];
    cachePkg::lineT dataArr [cachePkg::NUM_LINES];
    logic [cachePkg::NUM_LINES-1:0] validBits;
    logic [cachePkg::NUM_LINES-1:0] dirtyBits;

    cachePkg::tagT reqTag;
    cachePkg::indexT reqIndex;
    cachePkg::offsetT reqOffset;
    logic accept;
    logic hit;
    logic victimDirty;
    cachePkg::wordT storedWord;

    // request held during a miss.
    logic reqWriteQ;
    cachePkg::tagT tagQ;
    cachePkg::indexT idxQ;
    cachePkg::offsetT offQ;
    cachePkg::wordT wdataQ;

    logic fillDone;
    cachePkg::lineT fillLine;

    // ****************************************
    // lookup.
    // ****************************************
    assign reqOffset = reqAddr[cachePkg::OFFSET_BITS-1:0];
    assign reqIndex = reqAddr[cachePkg::OFFSET_BITS +: cachePkg::INDEX_BITS];
    assign reqTag = reqAddr[cachePkg::WORD_BITS-1 -: cachePkg::TAG_BITS];

    assign reqReady = (state == cachePkg::idle) && initDone && !ev.invalidate;
    assign accept = reqValid && reqReady;
    assign hit = validBits[reqIndex] && (tagArr[reqIndex] == reqTag);
    assign victimDirty = validBits[reqIndex] && dirtyBits[reqIndex];
    assign storedWord = dataArr[reqIndex][reqOffset*cachePkg::WORD_BITS +: cachePkg::WORD_BITS];

    assign ev.hitEv = accept && hit;
    assign ev.missEv = accept && !hit;
    assign ev.writeBackEv = (state == cachePkg::writeBack) && mem.reqReady;

    // ****************************************
    // memory requests.
    // ****************************************
    assign mem.reqValid = (state == cachePkg::writeBack) || (state == cachePkg::fillReq);
    assign mem.reqWrite = (state == cachePkg::writeBack);
    assign mem.reqLineAddr = (state == cachePkg::writeBack) ? {tagArr[idxQ], idxQ} : {tagQ, idxQ};
    assign mem.reqData = dataArr[idxQ]; // victim line, only used on write-back.

    assign fillDone = (state == cachePkg::fillWait) && mem.rspValid;

    always_comb begin
        fillLine = mem.rspData;
        if (reqWriteQ) begin
            fillLine[offQ*cachePkg::WORD_BITS +: cachePkg::WORD_BITS] = wdataQ; // merge write word.
        end
    end

    // ****************************************
    // control.
    // ****************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cachePkg::idle;
            initDone <= 1'b0;
            rspValid <= 1'b0;
            rspHit <= 1'b0;
        end else begin
            initDone <= 1'b1;
            rspValid <= 1'b0;
            rspHit <= 1'b0;
            case (state)
                cachePkg::idle: begin
                    if (accept) begin
                        if (hit) begin
                            rspValid <= 1'b1;
                            rspHit <= 1'b1;
                        end else begin
                            state <= victimDirty ? cachePkg::writeBack : cachePkg::fillReq;
                        end
                    end
                end
                cachePkg::writeBack: if (mem.reqReady) state <= cachePkg::fillReq;
                cachePkg::fillReq: if (mem.reqReady) state <= cachePkg::fillWait;
                cachePkg::fillWait: if (mem.rspValid) state <= cachePkg::respond;
                cachePkg::respond: begin
                    rspValid <= 1'b1; // miss completes with rspHit low.
                    state <= cachePkg::idle;
                end
                default: state <= cachePkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else begin
            if (ev.invalidate) begin
                validBits <= '0;
                dirtyBits <= '0;
            end
            if (accept && hit && reqWrite) begin
                dirtyBits[reqIndex] <= 1'b1;
            end
            if (fillDone) begin
                validBits[idxQ] <= 1'b1;
                dirtyBits[idxQ] <= reqWriteQ;
            end
        end
    end

    // ****************************************
    // arrays and payload.
    // ****************************************
    always_ff @(posedge clk) begin
        if (accept) begin
            reqWriteQ <= reqWrite;
            tagQ <= reqTag;
            idxQ <= reqIndex;
            offQ <= reqOffset;
            wdataQ <= reqWriteData;
            rspData <= reqWrite ? reqWriteData : storedWord;
        end
        if (accept && hit && reqWrite) begin
            dataArr[reqIndex][reqOffset*cachePkg::WORD_BITS +: cachePkg::WORD_BITS] <= reqWriteData;
        end
        if (fillDone) begin
            tagArr[idxQ] <= tagQ;
            dataArr[idxQ] <= fillLine;
            rspData <= fillLine[offQ*cachePkg::WORD_BITS +: cachePkg::WORD_BITS];
        end
    end

endmodule

//--- hw/l3Subsystem.sv
`timescale 1ns/1ns

module l3Subsystem (
    input logic clk,
    input logic reset,
    // requester.
    input logic reqValid,
    input logic reqWrite,
    input cachePkg::addrT reqAddr,
    input cachePkg::wordT reqWriteData,
    output logic reqReady,
    output logic rspValid,
    output cachePkg::wordT rspData,
    output logic rspHit,
    // memory.
    output logic memReqValid,
    output logic memReqWrite,
    output cachePkg::lineAddrT memReqLineAddr,
    output cachePkg::lineT memReqData,
    input logic memCredit,
    input logic memRspValid,
    input cachePkg::lineT memRspData,
    // registers.
    input logic csrWrite,
    input cachePkg::csrAddrT csrAddr,
    input cachePkg::wordT csrWriteData,
    output cachePkg::cntT csrReadData
);

    memReqIf memBus ();
    cacheEventIf evBus ();

    l3Cache cache_i (
        .clk(clk),
        .reset(reset),
        .reqValid(reqValid),
        .reqWrite(reqWrite),
        .reqAddr(reqAddr),
        .reqWriteData(reqWriteData),
        .reqReady(reqReady),
        .rspValid(rspValid),
        .rspData(rspData),
        .rspHit(rspHit),
        .mem(memBus.cache),
        .ev(evBus.ctrl)
    );

    memCreditPort memPort_i (
        .clk(clk),
        .reset(reset),
        .memCredit(memCredit),
        .memRspValid(memRspValid),
        .memRspData(memRspData),
        .memReqValid(memReqValid),
        .memReqWrite(memReqWrite),
        .memReqLineAddr(memReqLineAddr),
        .memReqData(memReqData),
        .mem(memBus.port)
    );

    cacheCsr csr_i (
        .clk(clk),
        .reset(reset),
        .csrWrite(csrWrite),
        .csrAddr(csrAddr),
        .csrWriteData(csrWriteData),
        .csrReadData(csrReadData),
        .ev(evBus.csr)
    );

endmodule

//--- hw/memCreditPort.sv
`timescale 1ns/1ns

module memCreditPort (
    input logic clk,
    input logic reset,
    input logic memCredit,
    input logic memRspValid,
    input cachePkg::lineT memRspData,
    output logic memReqValid,
    output logic memReqWrite,
    output cachePkg::lineAddrT memReqLineAddr,
    output cachePkg::lineT memReqData,
    memReqIf.port mem
);

    cachePkg::creditT credits;
    logic send;

    assign mem.reqReady = (credits != '0);
    assign send = mem.reqValid && mem.reqReady;

    // read lines go straight back to the cache.
    assign mem.rspValid = memRspValid;
    assign mem.rspData = memRspData;

    // ****************************************
    // credit counter.
    // ****************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= cachePkg::CREDIT_BITS'(cachePkg::MEM_CREDITS);
        end else begin
            case ({send, memCredit})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits; // none, or one in and one out.
            endcase
        end
    end

    // ****************************************
    // request register.
    // ****************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memReqValid <= 1'b0;
        end else begin
            memReqValid <= send; // one cycle per accepted request.
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            memReqWrite <= mem.reqWrite;
            memReqLineAddr <= mem.reqLineAddr;
            memReqData <= mem.reqData;
        end
    end

endmodule

//--- hw/memReqIf.sv
`timescale 1ns/1ns

interface memReqIf;
    logic reqValid;
    logic reqWrite;
    cachePkg::lineAddrT reqLineAddr;
    cachePkg::lineT reqData;
    logic reqReady;              // at least one credit left.
    logic rspValid;              // one-cycle read line.
    cachePkg::lineT rspData;

    modport cache (
        output reqValid, reqWrite, reqLineAddr, reqData,
        input reqReady, rspValid, rspData
    );

    modport port (
        input reqValid, reqWrite, reqLineAddr, reqData,
        output reqReady, rspValid, rspData
    );

    modport monitor (
        input reqValid, reqWrite, reqLineAddr, reqData, reqReady, rspValid, rspData
    );
endinterface

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module l3SubsystemTb -o simv &&
./obj_dir/simv || exit 1

//--- verilog.f
hw/cachePkg.sv
hw/memReqIf.sv
hw/cacheEventIf.sv
hw/l3Cache.sv
hw/memCreditPort.sv
hw/cacheCsr.sv
hw/l3Subsystem.sv
dv/l3Subsystem_props.sv
dv/tbClock.sv
dv/l3SubsystemTb.sv
